// ==== design/alu_pkg.sv ====
// shared types and constants of the execute stage; modules import it with alu_pkg::*
`default_nettype none

package alu_pkg;

	typedef logic [7:0] byte_t;        // one data byte
	typedef logic [4:0] op_t;          // decoded operation code
	typedef logic [7:0] flags_t;       // S Z X H X P/V N C
	typedef logic [1:0] logic_kind_t;  // logic unit function

	// ====================
	// operation codes
	// ====================
	localparam op_t op_add   = 5'd1;
	localparam op_t op_adc   = 5'd2;
	localparam op_t op_sub   = 5'd3;
	localparam op_t op_sbc   = 5'd4;
	localparam op_t op_and   = 5'd5;
	localparam op_t op_xor   = 5'd6;
	localparam op_t op_or    = 5'd7;
	localparam op_t op_cp    = 5'd8;
	localparam op_t op_inc   = 5'd9;
	localparam op_t op_dec   = 5'd10;
	localparam op_t op_add16 = 5'd11;
	localparam op_t op_adc16 = 5'd12;
	localparam op_t op_sbc16 = 5'd13;

	// low three bits pick the shift in shift_rotate
	localparam op_t op_rlc   = 5'd17;
	localparam op_t op_rrc   = 5'd18;
	localparam op_t op_rl    = 5'd19;
	localparam op_t op_rr    = 5'd20;
	localparam op_t op_sla   = 5'd21;
	localparam op_t op_sra   = 5'd22;
	localparam op_t op_srl   = 5'd23;

	localparam op_t op_set   = 5'd26;
	localparam op_t op_res   = 5'd27;
	localparam op_t op_bit   = 5'd28;

	localparam logic_kind_t lk_and  = 2'd0;
	localparam logic_kind_t lk_or   = 2'd1;
	localparam logic_kind_t lk_xor  = 2'd2;
	localparam logic_kind_t lk_none = 2'd3;  // result forced to zero

	// ====================
	// flag bit positions
	// ====================
	localparam int flag_s  = 7;
	localparam int flag_z  = 6;
	localparam int flag_h  = 4;
	localparam int flag_pv = 2;
	localparam int flag_n  = 1;
	localparam int flag_c  = 0;

endpackage

`default_nettype wire

// ==== design/alu_writeback.sv ====
// picks the result and composes the flags per opcode, then registers them on exec_en
`timescale 1ns/100ps
`default_nettype none

module alu_writeback
	import alu_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   exec_en,
	input  op_t    operation,
	input  byte_t  operand_des,
	input  byte_t  operand_sou,
	input  flags_t flag_in,
	input  byte_t  sum_low,
	input  byte_t  sum_high,
	input  logic   half_carry_low,
	input  logic   carry_low,
	input  logic   overflow_low,
	input  logic   half_carry_high,
	input  logic   carry_high,
	input  logic   overflow_high,
	input  logic   add_sub,
	input  byte_t  logic_result,
	input  logic   logic_half_carry,
	input  logic   logic_parity,
	input  byte_t  shift_result,
	input  logic   shift_carry,
	output byte_t  result,
	output byte_t  result_high,
	output flags_t flag_out
);

	byte_t  next_result;
	byte_t  next_result_high;
	flags_t next_flags;
	logic   bit_zero;  // BIT test outcome

	assign bit_zero = ~operand_des[operand_sou[2:0]];

	// ====================
	// result and flag select
	// ====================
	always_comb begin
		next_result      = 8'h00;
		next_result_high = 8'h00;
		next_flags       = flag_in;  // X bits always pass
		case (operation)
			op_add, op_adc, op_sub, op_sbc, op_cp, op_inc, op_dec: begin
				next_result         = (operation == op_cp) ? operand_des : sum_low;
				next_flags[flag_s]  = sum_low[7];
				next_flags[flag_z]  = ~|sum_low;
				next_flags[flag_h]  = half_carry_low;
				next_flags[flag_pv] = overflow_low;
				next_flags[flag_n]  = add_sub;
				if (operation != op_inc && operation != op_dec) begin
					next_flags[flag_c] = carry_low;  // INC/DEC leave C alone
				end
			end
			op_and, op_xor, op_or: begin
				next_result         = logic_result;
				next_flags[flag_s]  = logic_result[7];
				next_flags[flag_z]  = ~|logic_result;
				next_flags[flag_h]  = logic_half_carry;
				next_flags[flag_pv] = logic_parity;
				next_flags[flag_n]  = 1'b0;
				next_flags[flag_c]  = 1'b0;
			end
			op_rlc, op_rrc, op_rl, op_rr, op_sla, op_sra, op_srl: begin
				next_result         = shift_result;
				next_flags[flag_s]  = shift_result[7];
				next_flags[flag_z]  = ~|shift_result;
				next_flags[flag_h]  = 1'b0;
				next_flags[flag_pv] = ~^shift_result;
				next_flags[flag_n]  = 1'b0;
				next_flags[flag_c]  = shift_carry;
			end
			op_set, op_res: next_result = logic_result;  // flags untouched
			op_bit: begin
				next_flags[flag_z] = bit_zero;
				next_flags[flag_h] = 1'b1;
				next_flags[flag_n] = 1'b0;
			end
			op_add16, op_adc16, op_sbc16: begin
				next_result        = sum_low;
				next_result_high   = sum_high;
				next_flags[flag_h] = half_carry_high;  // from bit 11
				next_flags[flag_n] = add_sub;
				next_flags[flag_c] = carry_high;
				if (operation != op_add16) begin
					next_flags[flag_s]  = sum_high[7];
					next_flags[flag_z]  = ~|{sum_high, sum_low};
					next_flags[flag_pv] = overflow_high;
				end
			end
			default: ;
		endcase
	end

	// ====================
	// output register
	// ====================
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			result      <= 8'h00;
			result_high <= 8'h00;
			flag_out    <= 8'h00;
		end else if (exec_en) begin
			result      <= next_result;
			result_high <= next_result_high;
			flag_out    <= next_flags;
		end
	end

endmodule

`default_nettype wire

// ==== design/byte_adder.sv ====
// one 8-bit add/subtract slice with half-carry and overflow, chained for 16-bit ops
`timescale 1ns/100ps
`default_nettype none

module byte_adder
	import alu_pkg::*;
(
	input  byte_t a,
	input  byte_t b,
	input  logic  sub,
	input  logic  cin,
	input  logic  en,
	output byte_t sum,
	output logic  half_carry,
	output logic  carry,
	output logic  overflow
);

	logic carry_6;  // carry into bit 7

	always_comb begin
		sum        = 8'h00;
		half_carry = 1'b0;
		carry_6    = 1'b0;
		carry      = 1'b0;
		if (en) begin
			if (sub) begin  // borrows ripple up
				{half_carry, sum[3:0]} = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'h0, cin};
				{carry_6, sum[6:4]} = {1'b0, a[6:4]} - {1'b0, b[6:4]} - {3'h0, half_carry};
				{carry, sum[7]} = {1'b0, a[7]} - {1'b0, b[7]} - {1'b0, carry_6};
			end else begin
				{half_carry, sum[3:0]} = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'h0, cin};
				{carry_6, sum[6:4]} = {1'b0, a[6:4]} + {1'b0, b[6:4]} + {3'h0, half_carry};
				{carry, sum[7]} = {1'b0, a[7]} + {1'b0, b[7]} + {1'b0, carry_6};
			end
		end
	end

	assign overflow = carry_6 ^ carry;  // signed overflow

endmodule

`default_nettype wire

// ==== design/instr_execute.sv ====
// execute stage top level; one operation per exec_en cycle, outputs valid one clock later
`timescale 1ns/100ps
`default_nettype none

module instr_execute
	import alu_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   exec_en,
	input  op_t    operation,
	input  byte_t  operand_des,
	input  byte_t  operand_des_high,
	input  byte_t  operand_sou,
	input  byte_t  operand_sou_high,
	input  flags_t flag_in,
	output byte_t  result,
	output byte_t  result_high,
	output flags_t flag_out
);

	byte_t       oper_a_low;
	byte_t       oper_b_low;
	byte_t       oper_a_high;
	byte_t       oper_b_high;
	logic        add_sub;
	logic        carry_in;
	logic        word_en;
	logic_kind_t logic_kind;

	byte_t       sum_low;
	byte_t       sum_high;
	logic        half_carry_low;
	logic        carry_low;
	logic        overflow_low;
	logic        half_carry_high;
	logic        carry_high;
	logic        overflow_high;

	byte_t       logic_result;
	logic        logic_half_carry;
	logic        logic_parity;
	byte_t       shift_result;
	logic        shift_carry;

	operand_decode u_operand_decode (
		.operation        (operation),
		.operand_des      (operand_des),
		.operand_sou      (operand_sou),
		.operand_des_high (operand_des_high),
		.operand_sou_high (operand_sou_high),
		.carry_flag       (flag_in[flag_c]),
		.oper_a_low       (oper_a_low),
		.oper_b_low       (oper_b_low),
		.oper_a_high      (oper_a_high),
		.oper_b_high      (oper_b_high),
		.add_sub          (add_sub),
		.carry_in         (carry_in),
		.word_en          (word_en),
		.logic_kind       (logic_kind)
	);

	byte_adder u_adder_low (
		.a          (oper_a_low),
		.b          (oper_b_low),
		.sub        (add_sub),
		.cin        (carry_in),
		.en         (1'b1),
		.sum        (sum_low),
		.half_carry (half_carry_low),
		.carry      (carry_low),
		.overflow   (overflow_low)
	);

	byte_adder u_adder_high (
		.a          (oper_a_high),
		.b          (oper_b_high),
		.sub        (add_sub),
		.cin        (carry_low),  // chained from the low byte
		.en         (word_en),
		.sum        (sum_high),
		.half_carry (half_carry_high),
		.carry      (carry_high),
		.overflow   (overflow_high)
	);

	logic_unit u_logic_unit (
		.a          (oper_a_low),
		.b          (oper_b_low),
		.kind       (logic_kind),
		.result     (logic_result),
		.half_carry (logic_half_carry),
		.parity     (logic_parity)
	);

	shift_rotate u_shift_rotate (
		.operation  (operation),
		.value      (operand_des),
		.carry_flag (flag_in[flag_c]),
		.result     (shift_result),
		.carry_out  (shift_carry)
	);

	alu_writeback u_alu_writeback (
		.clk              (clk),
		.reset            (reset),
		.exec_en          (exec_en),
		.operation        (operation),
		.operand_des      (operand_des),
		.operand_sou      (operand_sou),
		.flag_in          (flag_in),
		.sum_low          (sum_low),
		.sum_high         (sum_high),
		.half_carry_low   (half_carry_low),
		.carry_low        (carry_low),
		.overflow_low     (overflow_low),
		.half_carry_high  (half_carry_high),
		.carry_high       (carry_high),
		.overflow_high    (overflow_high),
		.add_sub          (add_sub),
		.logic_result     (logic_result),
		.logic_half_carry (logic_half_carry),
		.logic_parity     (logic_parity),
		.shift_result     (shift_result),
		.shift_carry      (shift_carry),
		.result           (result),
		.result_high      (result_high),
		.flag_out         (flag_out)
	);

endmodule

`default_nettype wire

// ==== design/logic_unit.sv ====
// AND/OR/XOR of two bytes with the half-carry and parity the flag logic needs
`timescale 1ns/100ps
`default_nettype none

module logic_unit
	import alu_pkg::*;
(
	input  byte_t       a,
	input  byte_t       b,
	input  logic_kind_t kind,
	output byte_t       result,
	output logic        half_carry,
	output logic        parity
);

	always_comb begin
		case (kind)
			lk_and:  result = a & b;
			lk_or:   result = a | b;
			lk_xor:  result = a ^ b;
			default: result = 8'h00;  // unit idle
		endcase
	end

	assign half_carry = (kind == lk_and);  // set by AND only
	assign parity     = ~^result;          // even parity

endmodule

`default_nettype wire

// ==== design/operand_decode.sv ====
// steers the operands and adder/logic controls for each opcode of the execute stage
`timescale 1ns/100ps
`default_nettype none

module operand_decode
	import alu_pkg::*;
(
	input  op_t         operation,
	input  byte_t       operand_des,
	input  byte_t       operand_sou,
	input  byte_t       operand_des_high,
	input  byte_t       operand_sou_high,
	input  logic        carry_flag,
	output byte_t       oper_a_low,
	output byte_t       oper_b_low,
	output byte_t       oper_a_high,
	output byte_t       oper_b_high,
	output logic        add_sub,
	output logic        carry_in,
	output logic        word_en,
	output logic_kind_t logic_kind
);

	byte_t bit_mask;  // one-hot bit select

	// index 8 and above selects no bit
	assign bit_mask = (operand_sou < 8'd8) ? byte_t'(8'h01 << operand_sou[2:0]) : 8'h00;

	always_comb begin
		oper_a_low  = operand_des;
		oper_b_low  = operand_sou;
		oper_a_high = operand_des_high;
		oper_b_high = operand_sou_high;
		add_sub     = 1'b0;
		carry_in    = 1'b0;
		word_en     = 1'b0;
		logic_kind  = lk_none;
		case (operation)
			op_adc: carry_in = carry_flag;
			op_sub, op_cp: add_sub = 1'b1;  // CP only keeps the flags
			op_sbc: begin
				add_sub  = 1'b1;
				carry_in = carry_flag;
			end
			op_and: logic_kind = lk_and;
			op_xor: logic_kind = lk_xor;
			op_or: logic_kind = lk_or;
			op_inc, op_dec: begin
				oper_a_low = operand_sou;  // source against one
				oper_b_low = 8'h01;
				add_sub    = (operation == op_dec);
			end
			op_add16: word_en = 1'b1;
			op_adc16: begin
				word_en  = 1'b1;
				carry_in = carry_flag;
			end
			op_sbc16: begin
				word_en  = 1'b1;
				add_sub  = 1'b1;
				carry_in = carry_flag;
			end
			op_set: begin
				oper_b_low = bit_mask;  // OR in the bit
				logic_kind = lk_or;
			end
			op_res: begin
				oper_b_low = ~bit_mask;  // mask out the bit
				logic_kind = lk_and;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/shift_rotate.sv ====
// the seven rotate and shift operations, picked by the low opcode bits
`timescale 1ns/100ps
`default_nettype none

module shift_rotate
	import alu_pkg::*;
(
	input  op_t   operation,
	input  byte_t value,
	input  logic  carry_flag,
	output byte_t result,
	output logic  carry_out
);

	always_comb begin
		result    = value;
		carry_out = carry_flag;
		case (operation[2:0])
			op_rlc[2:0]: {carry_out, result} = {value[7], value[6:0], value[7]};
			op_rrc[2:0]: {result, carry_out} = {value[0], value[7:1], value[0]};
			op_rl[2:0]:  {carry_out, result} = {value, carry_flag};  // through C
			op_rr[2:0]:  {result, carry_out} = {carry_flag, value};
			op_sla[2:0]: {carry_out, result} = {value, 1'b0};
			op_sra[2:0]: {result, carry_out} = {value[7], value};    // sign kept
			op_srl[2:0]: {result, carry_out} = {1'b0, value};
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
design/alu_pkg.sv
design/operand_decode.sv
design/byte_adder.sv
design/logic_unit.sv
design/shift_rotate.sv
design/alu_writeback.sv
design/instr_execute.sv
tests/tb_instr_execute.sv

// ==== include/alu_model.svh ====
// reference model of the execute stage for the testbench; include inside a module importing alu_pkg
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// expected {result_high, result, flags} of one operation
function automatic logic [23:0] model_execute(
	input op_t    op,
	input byte_t  des,
	input byte_t  des_high,
	input byte_t  sou,
	input byte_t  sou_high,
	input flags_t flag_in
);
	logic [15:0] wa;
	logic [15:0] wb;
	logic [16:0] wide;
	logic [12:0] mid;
	logic [8:0]  sum9;
	logic [4:0]  nib;
	byte_t       a;
	byte_t       b;
	byte_t       res;
	byte_t       res_high;
	flags_t      fl;
	logic        cin;
	logic        sub;
	logic        carry;

	res      = 8'h00;
	res_high = 8'h00;
	fl       = flag_in;
	sub      = (op == op_sub) || (op == op_sbc) || (op == op_cp) || (op == op_dec) ||
		(op == op_sbc16);
	cin      = ((op == op_adc) || (op == op_sbc) || (op == op_adc16) || (op == op_sbc16)) ?
		flag_in[flag_c] : 1'b0;
	a        = (op == op_inc || op == op_dec) ? sou : des;
	b        = (op == op_inc || op == op_dec) ? 8'h01 : sou;
	case (op)
		op_add, op_adc, op_sub, op_sbc, op_cp, op_inc, op_dec: begin
			sum9 = sub ? ({1'b0, a} - {1'b0, b} - cin) : ({1'b0, a} + {1'b0, b} + cin);
			nib  = sub ? ({1'b0, a[3:0]} - {1'b0, b[3:0]} - cin) :
				({1'b0, a[3:0]} + {1'b0, b[3:0]} + cin);
			res  = (op == op_cp) ? des : sum9[7:0];
			fl[flag_s]  = sum9[7];
			fl[flag_z]  = (sum9[7:0] == 8'h00);
			fl[flag_h]  = nib[4];
			fl[flag_pv] = ((a[7] ^ b[7]) == sub) && (sum9[7] != a[7]);
			fl[flag_n]  = sub;
			if (op != op_inc && op != op_dec) begin
				fl[flag_c] = sum9[8];
			end
		end
		op_and, op_xor, op_or: begin
			res = (op == op_and) ? (des & sou) : (op == op_or) ? (des | sou) : (des ^ sou);
			fl  = {res[7], res == 8'h00, flag_in[5], op == op_and, flag_in[3], ~^res, 2'b00};
		end
		op_rlc, op_rrc, op_rl, op_rr, op_sla, op_sra, op_srl: begin
			carry = (op == op_rlc || op == op_rl || op == op_sla) ? des[7] : des[0];
			case (op)
				op_rlc:  res = {des[6:0], des[7]};
				op_rrc:  res = {des[0], des[7:1]};
				op_rl:   res = {des[6:0], flag_in[flag_c]};
				op_rr:   res = {flag_in[flag_c], des[7:1]};
				op_sla:  res = {des[6:0], 1'b0};
				op_sra:  res = {des[7], des[7:1]};
				default: res = {1'b0, des[7:1]};
			endcase
			fl = {res[7], res == 8'h00, flag_in[5], 1'b0, flag_in[3], ~^res, 1'b0, carry};
		end
		op_set: begin
			res = des;
			if (sou < 8'd8) begin
				res[sou[2:0]] = 1'b1;  // larger index leaves the byte
			end
		end
		op_res: begin
			res = des;
			if (sou < 8'd8) begin
				res[sou[2:0]] = 1'b0;
			end
		end
		op_bit: begin
			fl[flag_z] = ~des[sou[2:0]];
			fl[flag_h] = 1'b1;
			fl[flag_n] = 1'b0;
		end
		op_add16, op_adc16, op_sbc16: begin
			wa   = {des_high, des};
			wb   = {sou_high, sou};
			wide = sub ? ({1'b0, wa} - {1'b0, wb} - cin) : ({1'b0, wa} + {1'b0, wb} + cin);
			mid  = sub ? ({1'b0, wa[11:0]} - {1'b0, wb[11:0]} - cin) :
				({1'b0, wa[11:0]} + {1'b0, wb[11:0]} + cin);
			{res_high, res} = wide[15:0];
			fl[flag_h] = mid[12];
			fl[flag_n] = sub;
			fl[flag_c] = wide[16];
			if (op != op_add16) begin
				fl[flag_s]  = wide[15];
				fl[flag_z]  = (wide[15:0] == 16'h0000);
				fl[flag_pv] = ((wa[15] ^ wb[15]) == sub) && (wide[15] != wa[15]);
			end
		end
		default: fl = flag_in;
	endcase
	return {res_high, res, fl};
endfunction

`endif

// ==== tests/tb_instr_execute.sv ====
// testbench for the execute stage; drives LFSR-chosen operations and checks them against the model
`timescale 1ns/100ps
`default_nettype none

module tb_instr_execute
	import alu_pkg::*;
();

	localparam int num_ops     = 2000;
	localparam int cycle_limit = 2 * num_ops + 20;

	logic        clk;
	logic        reset;
	logic        exec_en;
	op_t         operation;
	byte_t       operand_des;
	byte_t       operand_des_high;
	byte_t       operand_sou;
	byte_t       operand_sou_high;
	flags_t      flag_in;
	byte_t       result;
	byte_t       result_high;
	flags_t      flag_out;

	byte_t       exp_result;       // outputs the model predicts
	byte_t       exp_result_high;
	flags_t      exp_flags;
	op_t         last_op;          // opcode behind the expected values
	logic [31:0] lfsr_state;
	int          cycle_count;
	int          enabled_ops;
	op_t         kept_ops [23];

	`include "alu_model.svh"

	instr_execute u_dut (
		.clk              (clk),
		.reset            (reset),
		.exec_en          (exec_en),
		.operation        (operation),
		.operand_des      (operand_des),
		.operand_des_high (operand_des_high),
		.operand_sou      (operand_sou),
		.operand_sou_high (operand_sou_high),
		.flag_in          (flag_in),
		.result           (result),
		.result_high      (result_high),
		.flag_out         (flag_out)
	);

	always #50 clk = ~clk;  // 100 ns period

	// ====================
	// random source
	// ====================
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};  // x^32+x^22+x^2+x+1
	endfunction

	task automatic take_bits(input int count, output logic [31:0] value);
		value = 32'h0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value      = {value[30:0], lfsr_state[0]};  // one step per bit
		end
	endtask

	task automatic drive_random_op();
		logic [31:0] bits;
		op_t         op;
		byte_t       sou;
		take_bits(5, bits);
		op = kept_ops[bits % 23];
		take_bits(8, bits);
		operand_des <= bits[7:0];
		take_bits(8, bits);
		operand_des_high <= bits[7:0];
		take_bits(8, bits);
		sou = bits[7:0];
		if (op == op_set || op == op_res || op == op_bit) begin
			take_bits(1, bits);
			if (bits[0]) begin
				sou = sou & 8'h07;  // valid bit index half the time
			end
		end
		operand_sou <= sou;
		take_bits(8, bits);
		operand_sou_high <= bits[7:0];
		take_bits(8, bits);
		flag_in <= bits[7:0];
		take_bits(2, bits);
		exec_en   <= (bits[1:0] != 2'b00);  // enabled three times in four
		operation <= op;
	endtask

	// ====================
	// compare tasks
	// ====================
	task automatic check_byte(input string name, input byte_t actual, input byte_t expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s is %02h, expected %02h (opcode %0d)",
				$time, name, actual, expected, last_op);
			$display("Simulation failed");
			$fatal(1, "byte output compare error");
		end
	endtask

	task automatic check_flags(input flags_t actual, input flags_t expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: flag_out is %08b, expected %08b (opcode %0d)",
				$time, actual, expected, last_op);
			$display("Simulation failed");
			$fatal(1, "flag output compare error");
		end
	endtask

	// runaway guard
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: the run went past %0d clock cycles", cycle_limit);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		logic [23:0] predicted;
		int          i;
		clk              = 1'b0;
		reset            = 1'b0;
		exec_en          = 1'b0;
		operation        = 5'd0;
		operand_des      = 8'h00;
		operand_des_high = 8'h00;
		operand_sou      = 8'h00;
		operand_sou_high = 8'h00;
		flag_in          = 8'h00;
		exp_result       = 8'h00;  // reset values
		exp_result_high  = 8'h00;
		exp_flags        = 8'h00;
		last_op          = 5'd0;
		cycle_count      = 0;
		enabled_ops      = 0;
		lfsr_state       = 32'h5483_9ad0;
		kept_ops = '{op_add, op_adc, op_sub, op_sbc, op_and, op_xor, op_or, op_cp,
			op_inc, op_dec, op_add16, op_adc16, op_sbc16, op_rlc, op_rrc, op_rl,
			op_rr, op_sla, op_sra, op_srl, op_set, op_res, op_bit};

		repeat (4) @(posedge clk);
		reset <= 1'b1;

		// outputs of the edge before are checked, then this edge's op is predicted
		for (i = 0; i < num_ops + 2; i++) begin
			@(posedge clk);
			check_byte("result", result, exp_result);
			check_byte("result_high", result_high, exp_result_high);
			check_flags(flag_out, exp_flags);
			if (exec_en) begin
				predicted = model_execute(operation, operand_des, operand_des_high,
					operand_sou, operand_sou_high, flag_in);
				{exp_result_high, exp_result, exp_flags} = predicted;
				last_op     = operation;
				enabled_ops = enabled_ops + 1;
			end
			if (i < num_ops) begin
				drive_random_op();
			end else begin
				exec_en <= 1'b0;  // drain
			end
		end

		if (enabled_ops > num_ops / 2) begin
			$display("Simulation passed");
			$finish;
		end else begin
			$display("only %0d operations were enabled and checked", enabled_ops);
			$display("Simulation failed");
			$fatal(1, "too few checked operations");
		end
	end

endmodule

`default_nettype wire
